// ==== logic/cmd_macros.svh ====
// Command processor constants
`ifndef CMD_MACROS_SVH
`define CMD_MACROS_SVH

`define CMD_BYTES        8       // bytes per host command
`define CMD_QUEUE_DEPTH  4       // command FIFO entries
`define FW_VERSION       32'd26  // firmware version word

// opcodes kept by this board
`define OP_INFO          8'd2
`define OP_TRIG          8'd8
`define OP_DSAMP         8'd9
`define OP_BOARDOUT      8'd10
`define OP_READREG       8'd14

// info read sub-selects
`define INFO_VERSION     8'd0
`define INFO_BOARDIN     8'd1
`define INFO_OVERRANGE   8'd2
`define INFO_FAN         8'd6

// register readback sub-selects
`define RB_VERSION       8'd3
`define RB_BOARDIN       8'd4
`define RB_MERGING       8'd9
`define RB_DOWNSAMPLE    8'd10
`define RB_HIGHRES       8'd11
`define RB_UPPER_THRESH  8'd12

`define REPLY_W          32      // reply word width
`define THRESH_W         12      // trigger threshold width
`define DSAMP_W          5       // downsample factor width
`define OVR_CH           4       // overrange inputs
`define THRESH_MID       12'd128 // adc midscale in threshold math
`define THRESH_ROUND     12'd8   // half lsb after the shift

`endif

// ==== logic/cmd_pkg.sv ====
// Command processor types
`include "cmd_macros.svh"

package cmd_pkg;

   // opcode plus seven argument bytes, byte 0 on top
   typedef struct packed {
      logic [7:0] opcode;
      logic [7:0] b1;
      logic [7:0] b2;
      logic [7:0] b3;
      logic [7:0] b4;
      logic [7:0] b5;
      logic [7:0] b6;
      logic [7:0] b7;
   } cmd_setting_t;

   // view used by info read and register readback
   typedef struct packed {
      logic [7:0]  opcode;
      logic [7:0]  sel;    // sub-select
      logic [7:0]  arg;
      logic [39:0] unused;
   } cmd_select_t;

   typedef union packed {
      cmd_setting_t setting;
      cmd_select_t  select;
   } cmd_word_t;

   typedef logic [`REPLY_W-1:0] reply_t;

   typedef struct packed {
      logic signed [`THRESH_W-1:0] lower_thresh;
      logic signed [`THRESH_W-1:0] upper_thresh;
      logic [7:0]                  tot;  // time over threshold
      logic                        chan; // trigger channel
   } trig_settings_t;

endpackage

// ==== logic/cmd_receiver.sv ====
// Command byte assembler
`timescale 1ns/1ps
`include "cmd_macros.svh"

module cmd_receiver (
   input  logic               clk50,
   input  logic               pllreset2,
   input  logic               i_byte_valid,
   input  logic [7:0]         i_byte,
   output logic               o_byte_ready,
   output logic               o_cmd_valid,
   input  logic               i_cmd_ready,
   output cmd_pkg::cmd_word_t o_cmd
);

   import cmd_pkg::*;

   localparam int CNT_W = $clog2(`CMD_BYTES);

   logic [CNT_W-1:0] byte_cnt;
   logic             byte_take;
   logic             last_byte;

   // stall the host while a finished word sits here
   assign o_byte_ready = ~o_cmd_valid;
   assign byte_take    = i_byte_valid & o_byte_ready;
   assign last_byte    = (byte_cnt == CNT_W'(`CMD_BYTES - 1));

   always_ff @(posedge clk50) begin
      if (pllreset2) begin
         byte_cnt    <= '0;
         o_cmd_valid <= 1'b0;
      end else begin
         if (o_cmd_valid && i_cmd_ready) begin
            o_cmd_valid <= 1'b0; // word taken by the queue
         end
         if (byte_take) begin
            if (last_byte) begin
               byte_cnt    <= '0;
               o_cmd_valid <= 1'b1; // full command
            end else begin
               byte_cnt <= byte_cnt + 1'b1;
            end
         end
      end
   end

   // shift in at the bottom so byte 0 ends up as the opcode
   always_ff @(posedge clk50) begin
      if (byte_take) begin
         o_cmd <= {o_cmd[$bits(cmd_word_t)-9:0], i_byte};
      end
   end

endmodule

// ==== logic/cmd_queue.sv ====
// Command word FIFO
`timescale 1ns/1ps
`include "cmd_macros.svh"

module cmd_queue (
   input  logic               clk50,
   input  logic               pllreset2,
   input  logic               i_push_valid,
   output logic               o_push_ready,
   input  cmd_pkg::cmd_word_t i_push_data,
   output logic               o_pop_valid,
   input  logic               i_pop_ready,
   output cmd_pkg::cmd_word_t o_pop_data
);

   import cmd_pkg::*;

   localparam int PTR_W = $clog2(`CMD_QUEUE_DEPTH);
   localparam int OCC_W = $clog2(`CMD_QUEUE_DEPTH + 1);

   cmd_word_t        mem [`CMD_QUEUE_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [OCC_W-1:0] occ;   // entries held
   logic             push;
   logic             pop;

   assign o_push_ready = (occ != OCC_W'(`CMD_QUEUE_DEPTH));
   assign o_pop_valid  = (occ != '0);
   assign push         = i_push_valid & o_push_ready;
   assign pop          = o_pop_valid & i_pop_ready;
   assign o_pop_data   = mem[rd_ptr];

   always_ff @(posedge clk50) begin
      if (pllreset2) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         occ    <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1; // wraps at depth
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   occ <= occ + 1'b1;
            2'b01:   occ <= occ - 1'b1;
            default: occ <= occ; // idle or push and pop together
         endcase
      end
   end

   always_ff @(posedge clk50) begin
      if (push) begin
         mem[wr_ptr] <= i_push_data;
      end
   end

endmodule

// ==== logic/cmd_executor.sv ====
// Command decode and execute
`timescale 1ns/1ps
`include "cmd_macros.svh"

module cmd_executor (
   input  logic                    clk50,
   input  logic                    pllreset2,
   input  logic                    i_cmd_valid,
   output logic                    o_cmd_ready,
   input  cmd_pkg::cmd_word_t      i_cmd,
   output logic                    o_reply_valid,
   input  logic                    i_reply_ready,
   output cmd_pkg::reply_t         o_reply,
   input  logic [7:0]              i_boardin,
   input  logic [`OVR_CH-1:0]      i_overrange,
   output cmd_pkg::trig_settings_t o_trig,
   output logic [`DSAMP_W-1:0]     o_downsample,
   output logic                    o_highres,
   output logic [7:0]              o_downsample_merging,
   output logic [7:0]              o_boardout,
   output logic                    o_fan_on
);

   import cmd_pkg::*;

   logic [7:0]          boardin_sync;
   reply_t              ovr_cnt [`OVR_CH];
   logic                pop;
   logic                has_reply;  // opcode known
   reply_t              reply_next;
   logic [`THRESH_W-1:0] b1_ext;
   logic [`THRESH_W-1:0] b2_ext;
   logic [`THRESH_W-1:0] lower_calc;
   logic [`THRESH_W-1:0] upper_calc;

   // busy from the pop until the reply is taken
   assign o_cmd_ready = ~o_reply_valid;
   assign pop         = i_cmd_valid & o_cmd_ready;

   // threshold math wraps at 12 bits
   assign b1_ext     = `THRESH_W'(i_cmd.setting.b1);
   assign b2_ext     = `THRESH_W'(i_cmd.setting.b2);
   assign lower_calc = ((b1_ext - b2_ext - `THRESH_MID) << 4) + `THRESH_ROUND;
   assign upper_calc = ((b1_ext + b2_ext - `THRESH_MID) << 4) + `THRESH_ROUND;

   always_ff @(posedge clk50) begin
      boardin_sync <= i_boardin; // async board pins
   end

   always_ff @(posedge clk50) begin
      if (pllreset2) begin
         for (int k = 0; k < `OVR_CH; k++) begin
            ovr_cnt[k] <= '0;
         end
      end else begin
         for (int k = 0; k < `OVR_CH; k++) begin
            if (i_overrange[k]) begin
               ovr_cnt[k] <= ovr_cnt[k] + 1'b1; // counts cycles over range
            end
         end
      end
   end

   // reply value, read before any setting update lands
   always_comb begin
      has_reply  = 1'b1;
      reply_next = '0;
      case (i_cmd.setting.opcode)
         `OP_INFO: begin
            case (i_cmd.select.sel)
               `INFO_VERSION:   reply_next = `FW_VERSION;
               `INFO_BOARDIN:   reply_next = `REPLY_W'(boardin_sync);
               `INFO_OVERRANGE: reply_next = ovr_cnt[i_cmd.select.arg[1:0]];
               `INFO_FAN:       reply_next = `REPLY_W'(o_fan_on); // old fan bit
               default:         reply_next = '0;
            endcase
         end
         `OP_TRIG:     reply_next = `REPLY_W'(`OP_TRIG);
         `OP_DSAMP:    reply_next = `REPLY_W'(`OP_DSAMP);
         `OP_BOARDOUT: reply_next = `REPLY_W'(o_boardout);
         `OP_READREG: begin
            case (i_cmd.select.sel)
               `RB_VERSION:    reply_next = `FW_VERSION;
               `RB_BOARDIN:    reply_next = `REPLY_W'(boardin_sync);
               `RB_MERGING:    reply_next = `REPLY_W'(o_downsample_merging);
               `RB_DOWNSAMPLE: reply_next = `REPLY_W'(o_downsample);
               `RB_HIGHRES:    reply_next = `REPLY_W'(o_highres);
               `RB_UPPER_THRESH: begin
                  reply_next = {{(`REPLY_W-`THRESH_W){1'b0}}, o_trig.upper_thresh};
               end
               default:        reply_next = '0;
            endcase
         end
         default: has_reply = 1'b0; // unknown, dropped silently
      endcase
   end

   always_ff @(posedge clk50) begin
      if (pllreset2) begin
         o_reply_valid        <= 1'b0;
         o_trig               <= '0;
         o_downsample         <= '0;
         o_highres            <= 1'b0;
         o_downsample_merging <= '0;
         o_boardout           <= '0;
         o_fan_on             <= 1'b0;
      end else begin
         if (o_reply_valid && i_reply_ready) begin
            o_reply_valid <= 1'b0; // host took the reply
         end
         if (pop) begin
            o_reply_valid <= has_reply;
            case (i_cmd.setting.opcode)
               `OP_INFO: begin
                  if (i_cmd.select.sel == `INFO_FAN) begin
                     o_fan_on <= i_cmd.select.arg[0];
                  end
               end
               `OP_TRIG: begin
                  o_trig.lower_thresh <= lower_calc;
                  o_trig.upper_thresh <= upper_calc;
                  o_trig.tot          <= i_cmd.setting.b5;
                  o_trig.chan         <= i_cmd.setting.b6[0];
               end
               `OP_DSAMP: begin
                  o_downsample         <= i_cmd.setting.b1[`DSAMP_W-1:0];
                  o_highres            <= i_cmd.setting.b2[0];
                  o_downsample_merging <= i_cmd.setting.b3;
               end
               `OP_BOARDOUT: begin
                  o_boardout[i_cmd.setting.b1[2:0]] <= i_cmd.setting.b2[0]; // one relay bit
               end
               default: ; // readback and unknown change nothing
            endcase
         end
      end
   end

   always_ff @(posedge clk50) begin
      if (pop) begin
         o_reply <= reply_next;
      end
   end

endmodule

// ==== logic/command_top.sv ====
// Host command processor top
`timescale 1ns/1ps
`include "cmd_macros.svh"

module command_top (
   input  logic                        clk50,
   input  logic                        pllreset2,
   input  logic                        i_rx_valid,
   output logic                        o_rx_ready,
   input  logic [7:0]                  i_rx_data,
   output logic                        o_tx_valid,
   input  logic                        i_tx_ready,
   output logic [`REPLY_W-1:0]         o_tx_data,
   input  logic [7:0]                  i_boardin,
   input  logic [`OVR_CH-1:0]          i_overrange,
   output logic signed [`THRESH_W-1:0] o_lower_thresh,
   output logic signed [`THRESH_W-1:0] o_upper_thresh,
   output logic [7:0]                  o_trigger_tot,
   output logic                        o_trigger_chan,
   output logic [`DSAMP_W-1:0]         o_downsample,
   output logic                        o_highres,
   output logic [7:0]                  o_downsample_merging,
   output logic [7:0]                  o_boardout,
   output logic                        o_fan_on
);

   import cmd_pkg::*;

   cmd_word_t      rx_cmd;    // receiver to queue
   logic           rx_cmd_valid;
   logic           rx_cmd_ready;
   cmd_word_t      q_cmd;     // queue to executor
   logic           q_cmd_valid;
   logic           q_cmd_ready;
   trig_settings_t trig;

   assign o_lower_thresh = trig.lower_thresh;
   assign o_upper_thresh = trig.upper_thresh;
   assign o_trigger_tot  = trig.tot;
   assign o_trigger_chan = trig.chan;

   cmd_receiver u_receiver (
      .clk50        (clk50),
      .pllreset2    (pllreset2),
      .i_byte_valid (i_rx_valid),
      .i_byte       (i_rx_data),
      .o_byte_ready (o_rx_ready),
      .o_cmd_valid  (rx_cmd_valid),
      .i_cmd_ready  (rx_cmd_ready),
      .o_cmd        (rx_cmd)
   );

   cmd_queue u_queue (
      .clk50        (clk50),
      .pllreset2    (pllreset2),
      .i_push_valid (rx_cmd_valid),
      .o_push_ready (rx_cmd_ready),
      .i_push_data  (rx_cmd),
      .o_pop_valid  (q_cmd_valid),
      .i_pop_ready  (q_cmd_ready),
      .o_pop_data   (q_cmd)
   );

   cmd_executor u_executor (
      .clk50                (clk50),
      .pllreset2            (pllreset2),
      .i_cmd_valid          (q_cmd_valid),
      .o_cmd_ready          (q_cmd_ready),
      .i_cmd                (q_cmd),
      .o_reply_valid        (o_tx_valid),
      .i_reply_ready        (i_tx_ready),
      .o_reply              (o_tx_data),
      .i_boardin            (i_boardin),
      .i_overrange          (i_overrange),
      .o_trig               (trig),
      .o_downsample         (o_downsample),
      .o_highres            (o_highres),
      .o_downsample_merging (o_downsample_merging),
      .o_boardout           (o_boardout),
      .o_fan_on             (o_fan_on)
   );

endmodule

// ==== tests/cmd_checker.sv ====
// Reply and settings checker
`timescale 1ns/1ps

module cmd_checker (
   input  logic        clk50,
   input  logic        i_tx_valid,
   input  logic        i_tx_ready,
   input  logic [31:0] i_tx_data,
   input  logic [11:0] i_lower_thresh,
   input  logic [11:0] i_upper_thresh,
   input  logic [7:0]  i_trigger_tot,
   input  logic        i_trigger_chan,
   input  logic [4:0]  i_downsample,
   input  logic        i_highres,
   input  logic [7:0]  i_merging,
   input  logic [7:0]  i_boardout,
   input  logic        i_fan_on,
   input  logic        i_rx_valid,
   input  logic        i_rx_ready,
   output int          o_reply_count,
   output int          o_error_count,
   output logic        o_queue_stall_seen
);

   string       names [$];
   logic [31:0] exp_reply [$];
   int          exp_chk [$];   // which setting port follows the reply
   logic [31:0] exp_port [$];
   logic        trig_cmd [$];  // reply belongs to a trigger command
   logic [8:0]  exp_trig [$];  // channel bit above time over threshold
   int          rx_wait;       // cycles the current host byte has been held off

   // current value of the port a stim line asks about
   function automatic logic [31:0] port_value(input int chk);
      case (chk)
         1:       return {20'd0, i_lower_thresh};
         2:       return {20'd0, i_upper_thresh};
         3:       return {27'd0, i_downsample};
         4:       return {31'd0, i_highres};
         5:       return {24'd0, i_merging};
         6:       return {24'd0, i_boardout};
         7:       return {31'd0, i_fan_on};
         default: return 32'd0;
      endcase
   endfunction

   initial begin
      int          fd;
      int          cnt;
      string       line;
      string       name;
      logic [7:0]  cb [8];
      int          rep, chk, och, on, bp;
      logic [31:0] er, ep;
      logic [7:0]  bin;
      o_reply_count      = 0;
      o_error_count      = 0;
      o_queue_stall_seen = 1'b0;
      rx_wait            = 0;
      fd = $fopen("tests/cmd_stim.txt", "r");
      if (fd != 0) begin
         while (!$feof(fd)) begin
            line = "";
            cnt  = $fgets(line, fd);
            if (line.len() > 1 && line.substr(0, 0) != "#") begin
               cnt = $sscanf(line, "%s %h %h %h %h %h %h %h %h %d %h %d %h %h %d %d %d",
                             name, cb[0], cb[1], cb[2], cb[3], cb[4], cb[5], cb[6], cb[7],
                             rep, er, chk, ep, bin, och, on, bp);
               if (cnt == 17 && rep != 0) begin
                  names.push_back(name);
                  exp_reply.push_back(er);
                  exp_chk.push_back(chk);
                  exp_port.push_back(ep);
                  trig_cmd.push_back(cb[0] == 8'h08);
                  exp_trig.push_back({cb[6][0], cb[5]});
               end
            end
         end
         $fclose(fd);
      end
   end

   // a byte waits past one cycle only when the queue is full
   always @(negedge clk50) begin
      if (i_rx_valid === 1'b1 && i_rx_ready === 1'b0) begin
         rx_wait++;
         if (rx_wait > 1) o_queue_stall_seen = 1'b1;
      end else begin
         rx_wait = 0;
      end
   end

   // inputs settle mid cycle, so the negedge sees the coming transfer
   always @(negedge clk50) begin
      if (i_tx_valid === 1'b1 && i_tx_ready === 1'b1) begin
         if (o_reply_count >= names.size()) begin
            $display("Error: unexpected reply %h with no command waiting for it", i_tx_data);
            o_error_count++;
         end else begin
            if (i_tx_data !== exp_reply[o_reply_count]) begin
               $display("Fail %s reply: expected %h actual %h", names[o_reply_count],
                        exp_reply[o_reply_count], i_tx_data);
               o_error_count++;
            end
            if (exp_chk[o_reply_count] != 0 &&
                port_value(exp_chk[o_reply_count]) !== exp_port[o_reply_count]) begin
               $display("Fail %s port: expected %h actual %h", names[o_reply_count],
                        exp_port[o_reply_count], port_value(exp_chk[o_reply_count]));
               o_error_count++;
            end
            if (trig_cmd[o_reply_count] &&
                {i_trigger_chan, i_trigger_tot} !== exp_trig[o_reply_count]) begin
               $display("Fail %s trigger chan and tot: expected %h actual %h",
                        names[o_reply_count], exp_trig[o_reply_count],
                        {i_trigger_chan, i_trigger_tot});
               o_error_count++;
            end
         end
         o_reply_count++;
      end
   end

endmodule

// ==== tests/tb_command_top.sv ====
// Command processor testbench
`timescale 1ns/1ps

module tb_command_top;

   localparam int BYTE_WAIT  = 400;   // cycles for one byte handshake
   localparam int REPLY_WAIT = 800;   // cycles for outstanding replies

   logic        clk50;
   logic        pllreset2;
   logic        i_rx_valid;
   logic        o_rx_ready;
   logic [7:0]  i_rx_data;
   logic        o_tx_valid;
   logic        i_tx_ready;
   logic [31:0] o_tx_data;
   logic [7:0]  i_boardin;
   logic [3:0]  i_overrange;
   logic [11:0] o_lower_thresh;
   logic [11:0] o_upper_thresh;
   logic [7:0]  o_trigger_tot;
   logic        o_trigger_chan;
   logic [4:0]  o_downsample;
   logic        o_highres;
   logic [7:0]  o_downsample_merging;
   logic [7:0]  o_boardout;
   logic        o_fan_on;

   integer seed = 99;
   logic   bp_on;        // random reply back-pressure enable
   int     bp_left;
   int     timeouts;
   int     stall_errors;
   int     sent_replies; // replies the checker should have by now
   int     reply_count;
   int     error_count;
   logic   queue_stall_seen;

   initial clk50 = 1'b0;
   always #4 clk50 = ~clk50;

   command_top u_dut (
      .clk50 (clk50), .pllreset2 (pllreset2),
      .i_rx_valid (i_rx_valid), .o_rx_ready (o_rx_ready), .i_rx_data (i_rx_data),
      .o_tx_valid (o_tx_valid), .i_tx_ready (i_tx_ready), .o_tx_data (o_tx_data),
      .i_boardin (i_boardin), .i_overrange (i_overrange),
      .o_lower_thresh (o_lower_thresh), .o_upper_thresh (o_upper_thresh),
      .o_trigger_tot (o_trigger_tot), .o_trigger_chan (o_trigger_chan),
      .o_downsample (o_downsample), .o_highres (o_highres),
      .o_downsample_merging (o_downsample_merging),
      .o_boardout (o_boardout), .o_fan_on (o_fan_on)
   );

   cmd_checker u_check (
      .clk50 (clk50), .i_tx_valid (o_tx_valid), .i_tx_ready (i_tx_ready),
      .i_tx_data (o_tx_data), .i_lower_thresh (o_lower_thresh),
      .i_upper_thresh (o_upper_thresh), .i_trigger_tot (o_trigger_tot),
      .i_trigger_chan (o_trigger_chan), .i_downsample (o_downsample),
      .i_highres (o_highres), .i_merging (o_downsample_merging),
      .i_boardout (o_boardout), .i_fan_on (o_fan_on),
      .i_rx_valid (i_rx_valid), .i_rx_ready (o_rx_ready),
      .o_reply_count (reply_count), .o_error_count (error_count),
      .o_queue_stall_seen (queue_stall_seen)
   );

   // ready drops for long random stretches and comes back for short ones
   always @(posedge clk50) begin
      #1;
      if (!bp_on) begin
         i_tx_ready = 1'b1;
      end else if (bp_left == 0) begin
         i_tx_ready = ~i_tx_ready;
         if (i_tx_ready) begin
            bp_left = ($random(seed) & 7) + 1;
         end else begin
            bp_left = ($random(seed) & 31) + 96; // long enough to fill the queue
         end
      end else begin
         bp_left = bp_left - 1;
      end
   end

   task automatic send_byte(input logic [7:0] b, input string name);
      int   n;
      logic done;
      n          = 0;
      done       = 1'b0;
      i_rx_data  = b;
      i_rx_valid = 1'b1;
      while (!done && n < BYTE_WAIT) begin
         @(negedge clk50);
         if (o_rx_ready) done = 1'b1; // transfers on the coming edge
         else n++;
      end
      @(posedge clk50);
      #1;
      i_rx_valid = 1'b0;
      if (!done) begin
         $display("Timeout: %s byte was never accepted by the receiver", name);
         timeouts++;
      end
   endtask

   task automatic wait_replies(input string name);
      int n;
      n = 0;
      while (reply_count < sent_replies && n < REPLY_WAIT) begin
         @(posedge clk50);
         #1;
         n++;
      end
      if (reply_count < sent_replies) begin
         $display("Timeout: replies missing after %s (%0d of %0d)", name, reply_count,
                  sent_replies);
         timeouts++;
         sent_replies = reply_count; // resync so later waits stay meaningful
      end
   endtask

   task automatic pulse_overrange(input int ch, input int cycles);
      i_overrange[ch] = 1'b1;
      repeat (cycles) @(posedge clk50);
      #1;
      i_overrange = '0;
   endtask

   initial begin
      int          fd;
      int          cnt;
      string       line;
      string       name;
      logic [7:0]  cb [8];
      int          rep, chk, och, on, bp;
      logic [31:0] exp_reply, exp_port;
      logic [7:0]  bin;
      pllreset2    = 1'b1;
      i_rx_valid   = 1'b0;
      i_rx_data    = '0;
      i_tx_ready   = 1'b1;
      i_boardin    = '0;
      i_overrange  = '0;
      bp_on        = 1'b0;
      bp_left      = 0;
      timeouts     = 0;
      stall_errors = 0;
      sent_replies = 0;
      repeat (5) @(posedge clk50);
      #1;
      pllreset2 = 1'b0;
      repeat (2) @(posedge clk50);
      #1;
      fd = $fopen("tests/cmd_stim.txt", "r");
      if (fd == 0) begin
         $display("Error: could not open the stimulus file");
         timeouts++;
      end else begin
         while (!$feof(fd)) begin
            line = "";
            cnt  = $fgets(line, fd);
            if (line.len() > 1 && line.substr(0, 0) != "#") begin
               cnt = $sscanf(line, "%s %h %h %h %h %h %h %h %h %d %h %d %h %h %d %d %d",
                             name, cb[0], cb[1], cb[2], cb[3], cb[4], cb[5], cb[6], cb[7],
                             rep, exp_reply, chk, exp_port, bin, och, on, bp);
               if (cnt == 17) begin
                  if (bin != i_boardin || on > 0) begin
                     wait_replies(name); // quiet DUT before inputs change
                     i_boardin = bin;
                     if (on > 0) pulse_overrange(och, on);
                     repeat (3) @(posedge clk50); // through the input sync
                     #1;
                  end
                  bp_on = (bp != 0);
                  if (rep != 0) sent_replies++;
                  for (int k = 0; k < 8; k++) begin
                     send_byte(cb[k], name);
                  end
                  if (bp == 0) wait_replies(name);
               end
            end
         end
         $fclose(fd);
      end
      bp_on = 1'b0;
      wait_replies("last command");
      repeat (30) @(posedge clk50); // room for any stray reply
      if (!queue_stall_seen) begin
         $display("Error: back-pressure never filled the command queue");
         stall_errors++;
      end
      $display("errors: %0d compare, %0d timeout, %0d stall, %0d replies", error_count,
               timeouts, stall_errors, reply_count);
      if (error_count == 0 && timeouts == 0 && stall_errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// ==== tests/cmd_stim.txt ====
# name op b1 b2 b3 b4 b5 b6 b7 reply_flag reply port_sel port_value boardin ovr_ch ovr_cycles bp
# port_sel 1 lower 2 upper 3 downsample 4 highres 5 merging 6 boardout 7 fan, hex except flags
info_version 02 00 00 00 00 00 00 00 1 0000001a 0 0 00 0 0 0
rb_version 0e 03 00 00 00 00 00 00 1 0000001a 0 0 00 0 0 0
info_boardin 02 01 00 00 00 00 00 00 1 000000a5 0 0 a5 0 0 0
rb_boardin 0e 04 00 00 00 00 00 00 1 000000a5 0 0 a5 0 0 0
trig_mid 08 80 10 00 00 33 01 00 1 00000008 1 f08 a5 0 0 0
rb_upper_mid 0e 0c 00 00 00 00 00 00 1 00000108 2 108 a5 0 0 0
trig_wrap 08 ff ff 00 00 10 00 00 1 00000008 1 808 a5 0 0 0
rb_upper_wrap 0e 0c 00 00 00 00 00 00 1 000007e8 2 7e8 a5 0 0 0
dsamp_set 09 e5 03 a7 00 00 00 00 1 00000009 3 05 a5 0 0 0
rb_merging 0e 09 00 00 00 00 00 00 1 000000a7 5 a7 a5 0 0 0
rb_downsample 0e 0a 00 00 00 00 00 00 1 00000005 4 1 a5 0 0 0
rb_highres 0e 0b 00 00 00 00 00 00 1 00000001 0 0 a5 0 0 0
bout_set3 0a 03 01 00 00 00 00 00 1 00000000 6 08 a5 0 0 0
bout_set5 0a 0d ff 00 00 00 00 00 1 00000008 6 28 a5 0 0 0
bout_clr3 0a 03 00 00 00 00 00 00 1 00000028 6 20 a5 0 0 0
fan_on 02 06 01 00 00 00 00 00 1 00000000 7 1 a5 0 0 0
fan_off 02 06 00 00 00 00 00 00 1 00000001 7 0 a5 0 0 0
ovr_ch1 02 02 01 00 00 00 00 00 1 0000000d 0 0 a5 1 13 0
ovr_ch3 02 02 03 00 00 00 00 00 1 00000028 0 0 a5 3 40 0
ovr_ch0 02 02 00 00 00 00 00 00 1 00000000 0 0 a5 0 0 0
burst_rb_version 0e 03 00 00 00 00 00 00 1 0000001a 0 0 a5 0 0 1
burst_dsamp 09 1f 00 11 00 00 00 00 1 00000009 5 11 a5 0 0 1
burst_unknown_a 33 01 02 03 04 05 06 07 0 00000000 0 0 a5 0 0 1
burst_rb_dsamp 0e 0a 00 00 00 00 00 00 1 0000001f 0 0 a5 0 0 1
burst_bout7 0a 07 01 00 00 00 00 00 1 00000020 6 a0 a5 0 0 1
burst_unknown_b 77 00 00 00 00 00 00 00 0 00000000 0 0 a5 0 0 1
burst_info_version 02 00 00 00 00 00 00 00 1 0000001a 0 0 a5 0 0 1
burst_info_other 02 55 00 00 00 00 00 00 1 00000000 0 0 a5 0 0 1
burst_rb_highres 0e 0b 00 00 00 00 00 00 1 00000000 0 0 a5 0 0 1

// ==== sim.f ====
+incdir+logic
logic/cmd_pkg.sv
logic/cmd_receiver.sv
logic/cmd_queue.sv
logic/cmd_executor.sv
logic/command_top.sv
tests/cmd_checker.sv
tests/tb_command_top.sv
